// ==== source/lsu_pkg.sv ====
// Shared definitions for the data-memory side of the pipeline.
// Holds the bus widths, the load/store/atomic operation encodings,
// the read-word view used for lane selection and every struct that
// travels between execute, lsu, amo_unit, dmem and writeback.
// Modules pull these in with a wildcard import in their header.

package lsu_pkg;

    // Data and address width
    parameter int XLEN       = 32;
    parameter int XLEN_BYTES = XLEN / 8;
    parameter int RF_ADDR_W  = 5;

    typedef enum logic [2:0] {
        LD_OPS_NONE,
        LD_OPS_LB,
        LD_OPS_LBU,
        LD_OPS_LH,
        LD_OPS_LHU,
        LD_OPS_LW
    } type_ld_ops_e;

    typedef enum logic [1:0] {
        ST_OPS_NONE,
        ST_OPS_SB,
        ST_OPS_SH,
        ST_OPS_SW
    } type_st_ops_e;

    typedef enum logic [3:0] {
        AMO_OPS_NONE,
        AMO_OPS_SWAP,
        AMO_OPS_ADD,
        AMO_OPS_AND,
        AMO_OPS_OR,
        AMO_OPS_XOR,
        AMO_OPS_MIN,
        AMO_OPS_MAX,
        AMO_OPS_MINU,
        AMO_OPS_MAXU
    } type_amo_ops_e;

    // One bus read word seen whole or split into lanes
    typedef union packed {
        logic [XLEN-1:0]        word;
        logic [3:0][7:0]        bytes;
        logic [1:0][15:0]       hwords;
    } type_rdata_u;

    typedef struct packed {
        logic [XLEN-1:0]        alu_result;
        logic [XLEN-1:0]        rs2_data;
        type_ld_ops_e           ld_ops;
        type_st_ops_e           st_ops;
        type_amo_ops_e          amo_ops;
        logic [RF_ADDR_W-1:0]   rd_addr;
        logic                   rd_wr_req;
    } type_exe2lsu_s;

    typedef struct packed {
        logic [XLEN-1:0]        r_data;
        logic [RF_ADDR_W-1:0]   rd_addr;
        logic                   rd_wr_req;
    } type_lsu2wrb_s;

    typedef struct packed {
        logic [XLEN-1:0]        addr;
        logic [XLEN-1:0]        w_data;
        logic                   ld_req;
        logic                   st_req;
        type_st_ops_e           st_ops;
    } type_lsu2dbus_s;

    typedef struct packed {
        logic [XLEN-1:0]        r_data;
        logic                   ack;
    } type_dbus2lsu_s;

    typedef struct packed {
        type_amo_ops_e          amo_ops;
        logic [XLEN-1:0]        lsu_addr;
        logic [XLEN-1:0]        rs2_operand;
        logic [XLEN-1:0]        r_data;
        logic                   ack;
    } type_lsu2amo_s;

    typedef struct packed {
        logic                   ld_req;
        logic                   st_req;
        logic [XLEN-1:0]        w_data;
        logic [XLEN-1:0]        amo_wrb_data;
        logic                   amo_done;
    } type_amo2lsu_s;

endpackage

// ==== source/dmem.sv ====
// On-chip data memory behind the lsu data bus.
// Word array indexed above the byte offset, with byte-lane writes
// chosen by st_ops and the low address bits. Read data and the ack
// come one cycle after a request is taken.

`timescale 1ns/1ps

module dmem import lsu_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            arst_n_i,

    input  type_lsu2dbus_s  lsu2dbus_i,
    output type_dbus2lsu_s  dbus2lsu_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [XLEN-1:0]        mem [MEM_WORDS];
    logic [IDX_W-1:0]       word_idx;
    logic [XLEN_BYTES-1:0]  byte_en;
    logic [XLEN-1:0]        w_lanes;
    logic                   req_take;
    logic                   ack_ff;
    logic [XLEN-1:0]        rdata_ff;

    assign word_idx = lsu2dbus_i.addr[IDX_W+1:2];

    // A request still held in its ack cycle is the access just served
    assign req_take = (lsu2dbus_i.ld_req | lsu2dbus_i.st_req) & ~ack_ff;

    // Store data copied into every lane it may land in
    always_comb begin
        case (lsu2dbus_i.st_ops)
            ST_OPS_SB: begin
                byte_en = 4'b0001 << lsu2dbus_i.addr[1:0];
                w_lanes = {4{lsu2dbus_i.w_data[7:0]}};
            end
            ST_OPS_SH: begin
                byte_en = 4'b0011 << {lsu2dbus_i.addr[1], 1'b0};
                w_lanes = {2{lsu2dbus_i.w_data[15:0]}};
            end
            ST_OPS_SW: begin
                byte_en = 4'b1111;
                w_lanes = lsu2dbus_i.w_data;
            end
            default: begin
                byte_en = 4'b0000;
                w_lanes = lsu2dbus_i.w_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (req_take) begin
            rdata_ff <= mem[word_idx];
            for (int b = 0; b < XLEN_BYTES; b++) begin
                if (lsu2dbus_i.st_req && byte_en[b]) begin
                    mem[word_idx][b*8 +: 8] <= w_lanes[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_ff <= 1'b0;
        end else begin
            ack_ff <= req_take;
        end
    end

    assign dbus2lsu_o.r_data = rdata_ff;
    assign dbus2lsu_o.ack    = ack_ff;

endmodule : dmem

// ==== source/amo_unit.sv ====
// Read-modify-write sequencer for the RV32A memory operations.
// Asks lsu for a word load, keeps the old word on the bus ack,
// works out the new word from it and the rs2 operand, asks for the
// word store and then pulses amo_done with the old word for rd.
// Runs beside lsu on the same execute request.

`timescale 1ns/1ps

module amo_unit import lsu_pkg::*; (
    input  logic            clk,
    input  logic            arst_n_i,

    input  type_lsu2amo_s   lsu2amo_i,
    output type_amo2lsu_s   amo2lsu_o
);

    typedef enum logic [1:0] {
        AMO_IDLE,
        AMO_READ,
        AMO_WRITE,
        AMO_DONE
    } type_amo_state_e;

    type_amo_state_e    state_ff;
    type_amo_state_e    state_next;
    logic [XLEN-1:0]    old_word;
    logic [XLEN-1:0]    rs2;
    logic [XLEN-1:0]    amo_result;
    logic [XLEN-1:0]    old_word_ff;
    logic [XLEN-1:0]    new_word_ff;

    assign old_word = lsu2amo_i.r_data;
    assign rs2      = lsu2amo_i.rs2_operand;

    // New memory value from the word just read
    always_comb begin
        case (lsu2amo_i.amo_ops)
            AMO_OPS_SWAP: begin
                amo_result = rs2;
            end
            AMO_OPS_ADD: begin
                amo_result = old_word + rs2;
            end
            AMO_OPS_AND: begin
                amo_result = old_word & rs2;
            end
            AMO_OPS_OR: begin
                amo_result = old_word | rs2;
            end
            AMO_OPS_XOR: begin
                amo_result = old_word ^ rs2;
            end
            AMO_OPS_MIN: begin
                amo_result = ($signed(old_word) < $signed(rs2)) ? old_word : rs2;
            end
            AMO_OPS_MAX: begin
                amo_result = ($signed(old_word) > $signed(rs2)) ? old_word : rs2;
            end
            AMO_OPS_MINU: begin
                amo_result = (old_word < rs2) ? old_word : rs2;
            end
            AMO_OPS_MAXU: begin
                amo_result = (old_word > rs2) ? old_word : rs2;
            end
            default: begin
                amo_result = old_word;
            end
        endcase
    end

    always_comb begin
        state_next = state_ff;
        case (state_ff)
            AMO_IDLE: begin
                if (lsu2amo_i.amo_ops != AMO_OPS_NONE) begin
                    state_next = AMO_READ;
                end
            end
            AMO_READ: begin
                if (lsu2amo_i.ack) begin
                    state_next = AMO_WRITE;
                end
            end
            AMO_WRITE: begin
                if (lsu2amo_i.ack) begin
                    state_next = AMO_DONE;
                end
            end
            default: begin
                // Done lasts a single cycle
                state_next = AMO_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_ff <= AMO_IDLE;
        end else begin
            state_ff <= state_next;
        end
    end

    // Old and new words captured together on the read ack
    always_ff @(posedge clk) begin
        if ((state_ff == AMO_READ) && lsu2amo_i.ack) begin
            old_word_ff <= old_word;
            new_word_ff <= amo_result;
        end
    end

    assign amo2lsu_o.ld_req       = (state_ff == AMO_READ);
    assign amo2lsu_o.st_req       = (state_ff == AMO_WRITE);
    assign amo2lsu_o.w_data       = new_word_ff;
    assign amo2lsu_o.amo_wrb_data = old_word_ff;
    assign amo2lsu_o.amo_done     = (state_ff == AMO_DONE);

endmodule : amo_unit

// ==== source/lsu.sv ====
// Load/store unit between the execute stage and the data bus.
// Picks the bus request either from the execute request or, for an
// atomic operation, from amo_unit, and holds it in a register that
// clears on the bus acknowledge. Load data is cut to the addressed
// lane and sign or zero extended, then merged with the atomic result
// into one writeback word and one acknowledge pulse.

`timescale 1ns/1ps

module lsu import lsu_pkg::*; (
    input  logic            clk,
    input  logic            arst_n_i,

    input  type_exe2lsu_s   exe2lsu_i,

    input  type_amo2lsu_s   amo2lsu_i,
    output type_lsu2amo_s   lsu2amo_o,

    input  type_dbus2lsu_s  dbus2lsu_i,
    output type_lsu2dbus_s  lsu2dbus_o,

    output type_lsu2wrb_s   lsu2wrb_o,
    output logic            lsu_ack_o
);

    type_lsu2dbus_s     lsu2dbus_ff;
    type_lsu2dbus_s     lsu2dbus_next;
    type_rdata_u        rdata;
    logic [7:0]         rdata_byte;
    logic [15:0]        rdata_hword;
    logic [XLEN-1:0]    ld_data;
    logic               is_amo;

    assign is_amo = (exe2lsu_i.amo_ops != AMO_OPS_NONE);

    // Atomic operations drive the bus from amo_unit
    always_comb begin
        lsu2dbus_next.addr = exe2lsu_i.alu_result;
        if (is_amo) begin
            lsu2dbus_next.ld_req = amo2lsu_i.ld_req;
            lsu2dbus_next.st_req = amo2lsu_i.st_req;
            lsu2dbus_next.w_data = amo2lsu_i.w_data;
            lsu2dbus_next.st_ops = ST_OPS_SW;
        end else begin
            lsu2dbus_next.ld_req = (exe2lsu_i.ld_ops != LD_OPS_NONE);
            lsu2dbus_next.st_req = (exe2lsu_i.st_ops != ST_OPS_NONE);
            lsu2dbus_next.w_data = exe2lsu_i.rs2_data;
            lsu2dbus_next.st_ops = exe2lsu_i.st_ops;
        end
    end

    // Bus request register that drops in the cycle of the acknowledge
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lsu2dbus_ff <= '0;
        end else if (dbus2lsu_i.ack) begin
            lsu2dbus_ff <= '0;
        end else begin
            lsu2dbus_ff <= lsu2dbus_next;
        end
    end

    // Lane select uses the address of the access being answered
    assign rdata.word  = dbus2lsu_i.r_data;
    assign rdata_byte  = rdata.bytes[lsu2dbus_ff.addr[1:0]];
    assign rdata_hword = rdata.hwords[lsu2dbus_ff.addr[1]];

    always_comb begin
        case (exe2lsu_i.ld_ops)
            LD_OPS_LB: begin
                ld_data = {{24{rdata_byte[7]}}, rdata_byte};
            end
            LD_OPS_LBU: begin
                ld_data = {24'b0, rdata_byte};
            end
            LD_OPS_LH: begin
                ld_data = {{16{rdata_hword[15]}}, rdata_hword};
            end
            LD_OPS_LHU: begin
                ld_data = {16'b0, rdata_hword};
            end
            LD_OPS_LW: begin
                ld_data = rdata.word;
            end
            default: begin
                ld_data = '0;
            end
        endcase
    end

    // Atomic result takes priority for the writeback word
    always_comb begin
        lsu2wrb_o.rd_addr   = exe2lsu_i.rd_addr;
        lsu2wrb_o.rd_wr_req = exe2lsu_i.rd_wr_req;
        if (amo2lsu_i.amo_done) begin
            lsu2wrb_o.r_data = amo2lsu_i.amo_wrb_data;
        end else if (dbus2lsu_i.ack) begin
            lsu2wrb_o.r_data = ld_data;
        end else begin
            lsu2wrb_o.r_data = '0;
        end
    end

    // An atomic operation sees two bus acks but completes only once
    assign lsu_ack_o = is_amo ? amo2lsu_i.amo_done : dbus2lsu_i.ack;

    assign lsu2amo_o.amo_ops     = exe2lsu_i.amo_ops;
    assign lsu2amo_o.lsu_addr    = exe2lsu_i.alu_result;
    assign lsu2amo_o.rs2_operand = exe2lsu_i.rs2_data;
    assign lsu2amo_o.r_data      = dbus2lsu_i.r_data;
    assign lsu2amo_o.ack         = dbus2lsu_i.ack;

    assign lsu2dbus_o = lsu2dbus_ff;

endmodule : lsu

// ==== source/lsu_top.sv ====
// Top level of the data-memory side.
// Ties lsu to amo_unit and to the on-chip data memory, and passes the
// memory depth down. The execute request comes in here, and the
// writeback word and its acknowledge go back out.

`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic            clk,
    input  logic            arst_n_i,

    input  type_exe2lsu_s   exe2lsu_i,
    output type_lsu2wrb_s   lsu2wrb_o,
    output logic            lsu_ack_o
);

    type_lsu2dbus_s     lsu2dbus;
    type_dbus2lsu_s     dbus2lsu;
    type_lsu2amo_s      lsu2amo;
    type_amo2lsu_s      amo2lsu;

    lsu lsu0 (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .exe2lsu_i  (exe2lsu_i),
        .amo2lsu_i  (amo2lsu),
        .lsu2amo_o  (lsu2amo),
        .dbus2lsu_i (dbus2lsu),
        .lsu2dbus_o (lsu2dbus),
        .lsu2wrb_o  (lsu2wrb_o),
        .lsu_ack_o  (lsu_ack_o)
    );

    amo_unit amo_unit0 (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .lsu2amo_i  (lsu2amo),
        .amo2lsu_o  (amo2lsu)
    );

    dmem #(
        .MEM_WORDS  (MEM_WORDS)
    ) dmem0 (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .lsu2dbus_i (lsu2dbus),
        .dbus2lsu_o (dbus2lsu)
    );

endmodule : lsu_top

// ==== verif/tb_lsu_top.sv ====
// Testbench for the data-memory side of the pipeline.
// Builds a table of loads, stores, atomic operations and idle slots,
// with expected results from a reference memory model, then applies
// the table to lsu_top one request at a time and holds each request
// until lsu_ack_o. A watchdog ends a run that stops making progress.

`timescale 1ns/1ps

module tb_lsu_top import lsu_pkg::*; ();

    localparam int          MEM_WORDS         = 256;
    localparam int          IDX_W             = $clog2(MEM_WORDS);
    localparam int          RESET_CYCLES      = 8;
    localparam int          CYCLES_PER_VECTOR = 20;
    localparam int          IDLE_WAIT         = 10;
    localparam logic [31:0] SEED              = 32'h54341d17;

    typedef struct packed {
        type_exe2lsu_s      req;
        logic [XLEN-1:0]    exp_data;
        logic               chk_data;
    } type_vector_s;

    logic               clk = 1'b0;
    logic               arst_n_i;
    type_exe2lsu_s      exe2lsu;
    type_lsu2wrb_s      lsu2wrb;
    logic               lsu_ack;

    type_vector_s       vectors[$];
    string              vec_names[$];
    logic [XLEN-1:0]    ref_mem [MEM_WORDS];
    logic [31:0]        rng_state;
    logic               table_ready = 1'b0;
    int                 checks;
    int                 errors;

    lsu_top #(
        .MEM_WORDS  (MEM_WORDS)
    ) dut0 (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .exe2lsu_i  (exe2lsu),
        .lsu2wrb_o  (lsu2wrb),
        .lsu_ack_o  (lsu_ack)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // New memory word of an atomic operation
    function automatic logic [XLEN-1:0] amo_model(input type_amo_ops_e op,
                                                  input logic [XLEN-1:0] mem_w,
                                                  input logic [XLEN-1:0] opnd);
        logic lt_u;
        logic lt_s;
        lt_u = (mem_w < opnd);
        // Different signs decide the signed order by the sign bit alone
        lt_s = (mem_w[XLEN-1] != opnd[XLEN-1]) ? mem_w[XLEN-1] : lt_u;
        case (op)
            AMO_OPS_SWAP: return opnd;
            AMO_OPS_ADD:  return mem_w + opnd;
            AMO_OPS_AND:  return mem_w & opnd;
            AMO_OPS_OR:   return mem_w | opnd;
            AMO_OPS_XOR:  return mem_w ^ opnd;
            AMO_OPS_MIN:  return lt_s ? mem_w : opnd;
            AMO_OPS_MAX:  return lt_s ? opnd : mem_w;
            AMO_OPS_MINU: return lt_u ? mem_w : opnd;
            AMO_OPS_MAXU: return lt_u ? opnd : mem_w;
            default:      return mem_w;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] exp_val,
                               input logic [XLEN-1:0] act_val);
        checks++;
        if (act_val !== exp_val) begin
            errors++;
            $display("ERR %s expected 0x%08h actual 0x%08h at %0t", name, exp_val, act_val,
                     $time);
        end
    endtask

    // Appends one request and updates the reference memory the same way
    task automatic add_vector(input string name, input type_ld_ops_e ld,
                              input type_st_ops_e st, input type_amo_ops_e amo,
                              input logic [XLEN-1:0] addr, input logic [XLEN-1:0] rs2);
        type_vector_s       v;
        logic [IDX_W-1:0]   idx;
        logic [XLEN-1:0]    word;
        logic [XLEN-1:0]    mask;
        logic [7:0]         lane8;
        logic [15:0]        lane16;

        idx              = addr[IDX_W+1:2];
        word             = ref_mem[idx];
        lane8            = word[{addr[1:0], 3'b000} +: 8];
        lane16           = word[{addr[1], 4'b0000} +: 16];
        v                = '0;
        v.req.alu_result = addr;
        v.req.rs2_data   = rs2;
        v.req.ld_ops     = ld;
        v.req.st_ops     = st;
        v.req.amo_ops    = amo;
        v.req.rd_addr    = 5'(vectors.size() % 31 + 1);
        v.req.rd_wr_req  = (ld != LD_OPS_NONE) || (amo != AMO_OPS_NONE);
        v.chk_data       = v.req.rd_wr_req;
        if (amo != AMO_OPS_NONE) begin
            // rd gets the old word
            v.exp_data   = word;
            ref_mem[idx] = amo_model(amo, word, rs2);
        end else if (ld != LD_OPS_NONE) begin
            case (ld)
                LD_OPS_LB:  v.exp_data = {{24{lane8[7]}}, lane8};
                LD_OPS_LBU: v.exp_data = {24'h0, lane8};
                LD_OPS_LH:  v.exp_data = {{16{lane16[15]}}, lane16};
                LD_OPS_LHU: v.exp_data = {16'h0, lane16};
                default:    v.exp_data = word;
            endcase
        end else if (st != ST_OPS_NONE) begin
            case (st)
                ST_OPS_SB: mask = 32'h0000_00FF << {addr[1:0], 3'b000};
                ST_OPS_SH: mask = 32'h0000_FFFF << {addr[1], 4'b0000};
                default:   mask = '1;
            endcase
            ref_mem[idx] = (word & ~mask) | ((rs2 << {addr[1:0], 3'b000}) & mask);
        end
        vectors.push_back(v);
        vec_names.push_back(name);
    endtask

    task automatic build_table();
        logic [XLEN-1:0]    top_addr;
        logic [XLEN-1:0]    rs2;
        type_amo_ops_e      amo;

        top_addr = (MEM_WORDS - 1) * 4;
        // Full words first so later accesses read known data
        for (int k = 0; k < 6; k++) begin
            add_vector($sformatf("sw_w%0d", k), LD_OPS_NONE, ST_OPS_SW, AMO_OPS_NONE, 4 * k,
                       next_rand());
        end
        add_vector("sw_top", LD_OPS_NONE, ST_OPS_SW, AMO_OPS_NONE, top_addr, next_rand());
        // Upper bytes negative, lower bytes positive
        add_vector("sw_lanes", LD_OPS_NONE, ST_OPS_SW, AMO_OPS_NONE, 4,
                   (next_rand() & 32'h7F7F_7F7F) | 32'h8080_0000);
        for (int k = 0; k < 6; k++) begin
            add_vector($sformatf("lw_w%0d", k), LD_OPS_LW, ST_OPS_NONE, AMO_OPS_NONE, 4 * k, 0);
        end
        add_vector("lw_top", LD_OPS_LW, ST_OPS_NONE, AMO_OPS_NONE, top_addr, 0);
        add_vector("idle0", LD_OPS_NONE, ST_OPS_NONE, AMO_OPS_NONE, 0, 0);
        for (int k = 0; k < 4; k++) begin
            add_vector($sformatf("lb_off%0d", k), LD_OPS_LB, ST_OPS_NONE, AMO_OPS_NONE, 4 + k, 0);
            add_vector($sformatf("lbu_off%0d", k), LD_OPS_LBU, ST_OPS_NONE, AMO_OPS_NONE, 4 + k, 0);
        end
        for (int k = 0; k < 2; k++) begin
            add_vector($sformatf("lh_off%0d", 2 * k), LD_OPS_LH, ST_OPS_NONE, AMO_OPS_NONE,
                       4 + 2 * k, 0);
            add_vector($sformatf("lhu_off%0d", 2 * k), LD_OPS_LHU, ST_OPS_NONE, AMO_OPS_NONE,
                       4 + 2 * k, 0);
        end
        for (int k = 0; k < 4; k++) begin
            add_vector($sformatf("sb_off%0d", k), LD_OPS_NONE, ST_OPS_SB, AMO_OPS_NONE, 12 + k,
                       next_rand());
            add_vector($sformatf("lw_after_sb%0d", k), LD_OPS_LW, ST_OPS_NONE, AMO_OPS_NONE, 12, 0);
        end
        for (int k = 0; k < 2; k++) begin
            add_vector($sformatf("sh_off%0d", 2 * k), LD_OPS_NONE, ST_OPS_SH, AMO_OPS_NONE,
                       16 + 2 * k, next_rand());
            add_vector($sformatf("lw_after_sh%0d", 2 * k), LD_OPS_LW, ST_OPS_NONE, AMO_OPS_NONE,
                       16, 0);
        end
        for (int k = 1; k <= 9; k++) begin
            amo = type_amo_ops_e'(k);
            rs2 = next_rand();
            if (amo >= AMO_OPS_MIN) begin
                // Negative and unsigned-large old word against a positive operand
                add_vector($sformatf("sw_amo%0d", k), LD_OPS_NONE, ST_OPS_SW, AMO_OPS_NONE,
                           top_addr, next_rand() | 32'h8000_0000);
                rs2 = rs2 >> 1;
            end
            add_vector($sformatf("amo_op%0d", k), LD_OPS_NONE, ST_OPS_NONE, amo, top_addr, rs2);
            add_vector($sformatf("lw_after_amo%0d", k), LD_OPS_LW, ST_OPS_NONE, AMO_OPS_NONE,
                       top_addr, 0);
        end
        add_vector("idle1", LD_OPS_NONE, ST_OPS_NONE, AMO_OPS_NONE, 0, 0);
    endtask

    // Starts on a rising edge and returns on a rising edge
    task automatic run_vector(input int i);
        type_vector_s   v;
        int             cycles;
        logic           acked;

        v      = vectors[i];
        cycles = 0;
        acked  = 1'b0;
        #1;
        exe2lsu = v.req;
        if ((v.req.ld_ops == LD_OPS_NONE) && (v.req.st_ops == ST_OPS_NONE)
                && (v.req.amo_ops == AMO_OPS_NONE)) begin
            repeat (IDLE_WAIT) begin
                @(negedge clk);
                acked = acked | lsu_ack;
            end
            check_value({vec_names[i], "_no_ack"}, 0, acked);
        end else begin
            while (!acked) begin
                @(negedge clk);
                if (lsu_ack) begin
                    acked = 1'b1;
                end else begin
                    cycles++;
                end
            end
            if (v.req.amo_ops == AMO_OPS_NONE) begin
                check_value({vec_names[i], "_latency"}, 2, cycles);
            end
            check_value({vec_names[i], "_rd_addr"}, v.req.rd_addr, lsu2wrb.rd_addr);
            check_value({vec_names[i], "_rd_wr_req"}, v.req.rd_wr_req, lsu2wrb.rd_wr_req);
            if (v.chk_data) begin
                check_value({vec_names[i], "_data"}, v.exp_data, lsu2wrb.r_data);
            end
        end
        @(posedge clk);
    endtask

    initial begin
        arst_n_i  = 1'b0;
        exe2lsu   = '0;
        checks    = 0;
        errors    = 0;
        rng_state = SEED;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        @(posedge clk);
        foreach (vectors[i]) begin
            run_vector(i);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        int limit;
        wait (table_ready);
        limit = RESET_CYCLES + 1 + vectors.size() * CYCLES_PER_VECTOR;
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a request was never acknowledged", limit);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Simulation failed");
        $finish;
    end

endmodule : tb_lsu_top

// ==== filelist.f ====
source/lsu_pkg.sv
source/dmem.sv
source/amo_unit.sv
source/lsu.sv
source/lsu_top.sv
verif/tb_lsu_top.sv

// ==== Bender.yml ====
package:
  name: lsu_top

sources:
  - files:
      - source/lsu_pkg.sv
      - source/dmem.sv
      - source/amo_unit.sv
      - source/lsu.sv
      - source/lsu_top.sv
  - target: test
    files:
      - verif/tb_lsu_top.sv
